// ==== bench/tile_mem_checker.sv ====
/* Handshake and reset assertions bound into tile_mem_top.
   Response payload may switch when a higher-priority device arrives, so only valid is held. */
`timescale 1ns/1ps
`default_nettype none

module tile_mem_checker
(
  input wire                         clk_i,
  input wire                         rst_i,
  input wire tile_mem_pkg::mem_msg_s resp_o,
  input wire                         resp_v_o,
  input wire                         resp_ready_i,
  input wire tile_mem_pkg::mem_msg_s ext_cmd_o,
  input wire                         ext_cmd_v_o,
  input wire                         timer_irq_o,
  input wire                         software_irq_o
);

  // Stalled response stays offered
  resp_held: assert property (@(posedge clk_i) disable iff (rst_i)
    resp_v_o && !resp_ready_i |=> resp_v_o)
    else $error("response valid dropped while stalled, tag %h", resp_o.tag);

  // Local addresses reach the port only through the cache device
  ext_local_cache: assert property (@(posedge clk_i) disable iff (rst_i)
    ext_cmd_v_o && (ext_cmd_o.addr.flat < tile_mem_pkg::DRAM_BASE)
      |-> (ext_cmd_o.addr.lcl.dev == tile_mem_pkg::CACHE_DEV))
    else $error("external command for local address %h", ext_cmd_o.addr.flat);

  irq_after_reset: assert property (@(posedge clk_i)
    $past(rst_i) && !rst_i |-> !timer_irq_o && !software_irq_o)
    else $error("interrupt high right after reset");

endmodule

bind tile_mem_top tile_mem_checker chk
(
  .clk_i(clk_i), .rst_i(rst_i),
  .resp_o(resp_o), .resp_v_o(resp_v_o), .resp_ready_i(resp_ready_i),
  .ext_cmd_o(ext_cmd_o), .ext_cmd_v_o(ext_cmd_v_o),
  .timer_irq_o(timer_irq_o), .software_irq_o(software_irq_o)
);

`default_nettype wire

// ==== bench/tile_mem_tb.sv ====
/* Table-driven testbench for tile_mem_top with an external-memory model.
   One command is in flight at a time, except in the back-pressure priority test. */
`timescale 1ns/1ps
`default_nettype none

module tile_mem_tb;

  localparam logic [39:0] RESET_NPC = 40'h00_0000_1000;
  localparam logic [7:0]  DID       = 8'h5A;
  localparam int          N_TESTS   = 18;
  localparam int          LIMIT     = (N_TESTS + 2) * 64 + 100;

  typedef struct packed
  {
    tile_mem_pkg::mem_op_e op;
    logic [39:0]           addr;
    logic [63:0]           wdata;
    logic [3:0]            tag;
    logic [63:0]           exp_data;
    logic [6:0]            tol;
    logic                  ext;
    logic                  exp_timer;
    logic                  exp_soft;
  } entry_s;

  logic clk_i, rst_i, cmd_v_i, resp_ready_i, ext_cmd_ready_i, ext_resp_v_i;
  logic cmd_ready_o, resp_v_o, ext_cmd_v_o, ext_resp_ready_o, timer_irq_o, software_irq_o;
  logic [7:0]             did_i;
  tile_mem_pkg::mem_msg_s cmd_i, resp_o, ext_cmd_o, ext_resp_i;
  tile_mem_pkg::cfg_bus_s cfg_bus_o;

  entry_s                 tests [N_TESTS];
  logic [63:0]            ext_mem [logic [39:0]];
  tile_mem_pkg::mem_msg_s rx_q [$];
  tile_mem_pkg::mem_msg_s want_msg, pend_msg;
  logic                   want_cmd, pend_v, hold_ready, cur_ext;
  logic [39:0]            cur_addr;
  logic [7:0]             lfsr;
  int                     cycles;

  tile_mem_top #(.RESET_NPC(RESET_NPC)) dut
  (
    .clk_i(clk_i), .rst_i(rst_i), .did_i(did_i),
    .cmd_i(cmd_i), .cmd_v_i(cmd_v_i), .cmd_ready_o(cmd_ready_o),
    .resp_o(resp_o), .resp_v_o(resp_v_o), .resp_ready_i(resp_ready_i),
    .ext_cmd_o(ext_cmd_o), .ext_cmd_v_o(ext_cmd_v_o), .ext_cmd_ready_i(ext_cmd_ready_i),
    .ext_resp_i(ext_resp_i), .ext_resp_v_i(ext_resp_v_i), .ext_resp_ready_o(ext_resp_ready_o),
    .cfg_bus_o(cfg_bus_o), .timer_irq_o(timer_irq_o), .software_irq_o(software_irq_o)
  );

  always #4 clk_i = ~clk_i;

  // Taps 8,6,5,4
  function automatic logic [7:0] lfsr_step(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  function automatic logic [39:0] local_addr(input logic [3:0] dev, input logic [19:0] ofs);
    return {16'h0000, dev, ofs};
  endfunction

  function automatic tile_mem_pkg::mem_msg_s make_msg(input tile_mem_pkg::mem_op_e op,
                                                      input logic [39:0] addr,
                                                      input logic [63:0] data,
                                                      input logic [3:0] tag);
    tile_mem_pkg::mem_msg_s m;
    m.op = op;
    m.addr.flat = addr;
    m.data = data;
    m.tag = tag;
    return m;
  endfunction

  function automatic entry_s make_entry(input tile_mem_pkg::mem_op_e op,
                                        input logic [39:0] addr, input logic [63:0] wdata,
                                        input logic [3:0] tag, input logic [63:0] exp_data,
                                        input logic [6:0] tol, input logic ext,
                                        input logic exp_timer, input logic exp_soft);
    entry_s e;
    e.op = op;
    e.addr = addr;
    e.wdata = wdata;
    e.tag = tag;
    e.exp_data = exp_data;
    e.tol = tol;
    e.ext = ext;
    e.exp_timer = exp_timer;
    e.exp_soft = exp_soft;
    return e;
  endfunction

  task automatic stop_run();
    $display("Checks failed");
    $fatal(1, "run stopped at cycle %0d", cycles);
  endtask

  task automatic check_msg(input string name, input tile_mem_pkg::mem_msg_s exp,
                           input tile_mem_pkg::mem_msg_s act);
    if (act !== exp)
    begin
      $display("[ERROR] %s expected %h actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_cfg(input string name, input tile_mem_pkg::cfg_bus_s exp,
                           input tile_mem_pkg::cfg_bus_s act);
    if (act !== exp)
    begin
      $display("[ERROR] %s expected %h actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("[ERROR] %s expected %b actual %b", name, exp, act);
      stop_run();
    end
  endtask

  // External memory answers one cycle after it takes a command
  task automatic model_take();
    tile_mem_pkg::mem_msg_s r;
    if (!cur_ext || ext_cmd_o.addr.flat !== cur_addr)
    begin
      $display("Unexpected external command for address %h", ext_cmd_o.addr.flat);
      stop_run();
    end
    r = ext_cmd_o;
    if (ext_cmd_o.op == tile_mem_pkg::MEM_WR)
    begin
      ext_mem[ext_cmd_o.addr.flat] = ext_cmd_o.data;
      r.data = '0;
    end
    else
      r.data = ext_mem.exists(ext_cmd_o.addr.flat) ? ext_mem[ext_cmd_o.addr.flat] : 64'h0;
    pend_msg = r;
    pend_v = 1'b1;
  endtask

  // Drive at the falling edge, then decide what the next rising edge transfers
  task automatic step_cycle();
    @(negedge clk_i);
    cycles++;
    if (cycles > LIMIT)
    begin
      $display("Timeout after %0d cycles without finishing the tests", cycles);
      stop_run();
    end
    lfsr = lfsr_step(lfsr);
    resp_ready_i = hold_ready ? 1'b0 : lfsr[0];
    cmd_v_i = want_cmd;
    cmd_i = want_msg;
    ext_resp_v_i = pend_v;
    ext_resp_i = pend_msg;
    #1;
    if (ext_resp_v_i && ext_resp_ready_o)
      pend_v = 1'b0;
    if (ext_cmd_v_o && ext_cmd_ready_i)
      model_take();
    if (resp_v_o && resp_ready_i)
      rx_q.push_back(resp_o);
    if (cmd_v_i && cmd_ready_o)
      want_cmd = 1'b0;
  endtask

  task automatic send_cmd(input tile_mem_pkg::mem_op_e op, input logic [39:0] addr,
                          input logic [63:0] data, input logic [3:0] tag);
    want_msg = make_msg(op, addr, data, tag);
    want_cmd = 1'b1;
    while (want_cmd)
      step_cycle();
  endtask

  task automatic run_entry(input int idx);
    entry_s                 e;
    tile_mem_pkg::mem_msg_s exp;
    tile_mem_pkg::mem_msg_s act;
    string                  name;
    e = tests[idx];
    name = $sformatf("entry %0d", idx);
    cur_addr = e.addr;
    cur_ext = e.ext;
    send_cmd(e.op, e.addr, e.wdata, e.tag);
    while (rx_q.size() == 0)
      step_cycle();
    act = rx_q.pop_front();
    exp = make_msg(e.op, e.addr, e.exp_data, e.tag);
    // mtime keeps counting between write and read
    if (e.tol != 0 && act.data >= e.exp_data && act.data <= e.exp_data + 64'(e.tol))
      exp.data = act.data;
    check_msg(name, exp, act);
    check_bit({name, " timer_irq"}, e.exp_timer, timer_irq_o);
    check_bit({name, " software_irq"}, e.exp_soft, software_irq_o);
    cur_ext = 1'b0;
  endtask

  initial
  begin
    tile_mem_pkg::cfg_bus_s cfg_exp;
    tile_mem_pkg::mem_msg_s act;
    tile_mem_pkg::mem_msg_s cfg_msg;
    tile_mem_pkg::mem_msg_s clint_msg;
    logic [39:0]            cfg_a, clint_a, cache_a, loop_a;
    clk_i = 1'b0;
    rst_i = 1'b1;
    did_i = DID;
    cmd_i = '0;
    cmd_v_i = 1'b0;
    resp_ready_i = 1'b0;
    ext_cmd_ready_i = 1'b1;
    ext_resp_i = '0;
    ext_resp_v_i = 1'b0;
    want_cmd = 1'b0;
    want_msg = '0;
    pend_v = 1'b0;
    pend_msg = '0;
    hold_ready = 1'b0;
    cur_ext = 1'b0;
    cur_addr = '0;
    lfsr = 8'd37;
    cycles = 0;
    cfg_a = local_addr(tile_mem_pkg::CFG_DEV, 20'h0);
    clint_a = local_addr(tile_mem_pkg::CLINT_DEV, 20'h0);
    cache_a = local_addr(tile_mem_pkg::CACHE_DEV, 20'h00100);
    loop_a = local_addr(4'd5, 20'h00020);

    tests[0]  = make_entry(tile_mem_pkg::MEM_WR, cfg_a | 40'(tile_mem_pkg::CFG_NPC_OFS),
                           64'h12_3456_7000, 4'd1, 64'h0, 7'd0, 1'b0, 1'b0, 1'b0);
    tests[1]  = make_entry(tile_mem_pkg::MEM_RD, cfg_a | 40'(tile_mem_pkg::CFG_NPC_OFS),
                           64'h0, 4'd2, 64'h12_3456_7000, 7'd0, 1'b0, 1'b0, 1'b0);
    tests[2]  = make_entry(tile_mem_pkg::MEM_WR, cfg_a | 40'(tile_mem_pkg::CFG_FREEZE_OFS),
                           64'h0, 4'd3, 64'h0, 7'd0, 1'b0, 1'b0, 1'b0);
    tests[3]  = make_entry(tile_mem_pkg::MEM_RD, cfg_a | 40'(tile_mem_pkg::CFG_FREEZE_OFS),
                           64'h0, 4'd4, 64'h0, 7'd0, 1'b0, 1'b0, 1'b0);
    tests[4]  = make_entry(tile_mem_pkg::MEM_RD, cfg_a | 40'(tile_mem_pkg::CFG_DID_OFS),
                           64'h0, 4'd5, 64'(DID), 7'd0, 1'b0, 1'b0, 1'b0);
    tests[5]  = make_entry(tile_mem_pkg::MEM_WR, clint_a | 40'(tile_mem_pkg::CLINT_MSIP_OFS),
                           64'h1, 4'd6, 64'h0, 7'd0, 1'b0, 1'b0, 1'b1);
    tests[6]  = make_entry(tile_mem_pkg::MEM_WR, clint_a | 40'(tile_mem_pkg::CLINT_MSIP_OFS),
                           64'h0, 4'd7, 64'h0, 7'd0, 1'b0, 1'b0, 1'b0);
    tests[7]  = make_entry(tile_mem_pkg::MEM_WR, clint_a | 40'(tile_mem_pkg::CLINT_MTIMECMP_OFS),
                           64'h0, 4'd8, 64'h0, 7'd0, 1'b0, 1'b1, 1'b0);
    tests[8]  = make_entry(tile_mem_pkg::MEM_WR, clint_a | 40'(tile_mem_pkg::CLINT_MTIMECMP_OFS),
                           '1, 4'd9, 64'h0, 7'd0, 1'b0, 1'b0, 1'b0);
    tests[9]  = make_entry(tile_mem_pkg::MEM_WR, clint_a | 40'(tile_mem_pkg::CLINT_MTIME_OFS),
                           64'h1000, 4'd10, 64'h0, 7'd0, 1'b0, 1'b0, 1'b0);
    tests[10] = make_entry(tile_mem_pkg::MEM_RD, clint_a | 40'(tile_mem_pkg::CLINT_MTIME_OFS),
                           64'h0, 4'd11, 64'h1000, 7'd64, 1'b0, 1'b0, 1'b0);
    tests[11] = make_entry(tile_mem_pkg::MEM_WR, 40'h80_0000_0040, 64'hA5A5_0001,
                           4'd12, 64'h0, 7'd0, 1'b1, 1'b0, 1'b0);
    tests[12] = make_entry(tile_mem_pkg::MEM_RD, 40'h80_0000_0040, 64'h0,
                           4'd13, 64'hA5A5_0001, 7'd0, 1'b1, 1'b0, 1'b0);
    tests[13] = make_entry(tile_mem_pkg::MEM_WR, cache_a, 64'h77, 4'd14, 64'h0,
                           7'd0, 1'b1, 1'b0, 1'b0);
    tests[14] = make_entry(tile_mem_pkg::MEM_RD, cache_a, 64'h0, 4'd15, 64'h77,
                           7'd0, 1'b1, 1'b0, 1'b0);
    tests[15] = make_entry(tile_mem_pkg::MEM_RD, 40'h80_0000_1000, 64'h0, 4'd0, 64'h0,
                           7'd0, 1'b1, 1'b0, 1'b0);
    tests[16] = make_entry(tile_mem_pkg::MEM_WR, loop_a, 64'hFFFF, 4'd1, 64'h0,
                           7'd0, 1'b0, 1'b0, 1'b0);
    tests[17] = make_entry(tile_mem_pkg::MEM_RD, loop_a, 64'h0, 4'd2, 64'h0,
                           7'd0, 1'b0, 1'b0, 1'b0);

    repeat (10) @(negedge clk_i);
    rst_i = 1'b0;
    step_cycle();
    check_bit("reset resp_v", 1'b0, resp_v_o);
    check_bit("reset ext_cmd_v", 1'b0, ext_cmd_v_o);
    check_bit("reset timer_irq", 1'b0, timer_irq_o);
    check_bit("reset software_irq", 1'b0, software_irq_o);
    cfg_exp = '{freeze: 1'b1, npc: RESET_NPC, did: DID};
    check_cfg("reset cfg_bus", cfg_exp, cfg_bus_o);

    for (int i = 0; i < N_TESTS; i++)
      run_entry(i);
    cfg_exp = '{freeze: 1'b0, npc: 40'h12_3456_7000, did: DID};
    check_cfg("cfg_bus after writes", cfg_exp, cfg_bus_o);

    // Priority: clint held first, cfg must still win
    clint_msg = make_msg(tile_mem_pkg::MEM_RD, clint_a | 40'(tile_mem_pkg::CLINT_MSIP_OFS),
                         64'h0, 4'd9);
    cfg_msg = make_msg(tile_mem_pkg::MEM_RD, cfg_a | 40'(tile_mem_pkg::CFG_DID_OFS),
                       64'(DID), 4'd10);
    hold_ready = 1'b1;
    send_cmd(tile_mem_pkg::MEM_RD, clint_a | 40'(tile_mem_pkg::CLINT_MSIP_OFS), 64'h0, 4'd9);
    send_cmd(tile_mem_pkg::MEM_RD, cfg_a | 40'(tile_mem_pkg::CFG_DID_OFS), 64'h0, 4'd10);
    repeat (3) step_cycle();
    check_bit("response offered while stalled", 1'b1, resp_v_o);
    check_msg("stalled response", cfg_msg, resp_o);
    hold_ready = 1'b0;
    while (rx_q.size() < 2)
      step_cycle();
    repeat (8) step_cycle();
    check_bit("exactly two responses", 1'b1, rx_q.size() == 2);
    act = rx_q.pop_front();
    check_msg("first response after stall", cfg_msg, act);
    act = rx_q.pop_front();
    check_msg("second response after stall", clint_msg, act);

    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== design/cfg_regs.sv ====
/* Configuration registers: freeze, next PC and device ID (read only).
   One response buffered; no new command is taken until it leaves. */
`timescale 1ns/1ps
`default_nettype none

module cfg_regs
#(
  parameter logic [tile_mem_pkg::ADDR_W-1:0] RESET_NPC = '0
)
(
  input  wire                                clk_i,
  input  wire                                rst_i,

  input  wire tile_mem_pkg::mem_msg_s        cmd_i,
  input  wire                                cmd_v_i,
  output logic                               cmd_ready_o,

  output tile_mem_pkg::mem_msg_s             resp_o,
  output logic                               resp_v_o,
  input  wire                                resp_ready_i,

  input  wire [tile_mem_pkg::DID_W-1:0]      did_i,
  output tile_mem_pkg::cfg_bus_s             cfg_bus_o
);

  logic                                freeze_q;
  logic [tile_mem_pkg::ADDR_W-1:0]     npc_q;
  logic                                resp_v_q;
  tile_mem_pkg::mem_msg_s              resp_q;
  logic                                take;
  logic                                wr;
  logic [tile_mem_pkg::OFS_W-1:0]      ofs;
  logic [tile_mem_pkg::DATA_W-1:0]     rd_data;

  assign cmd_ready_o = ~resp_v_q;
  assign take        = cmd_v_i & cmd_ready_o;
  assign wr          = (cmd_i.op == tile_mem_pkg::MEM_WR);
  assign ofs         = cmd_i.addr.lcl.ofs;

  always_comb
  begin
    rd_data = '0;
    if (!wr)
    begin
      case (ofs)
        tile_mem_pkg::CFG_FREEZE_OFS: rd_data = tile_mem_pkg::DATA_W'(freeze_q);
        tile_mem_pkg::CFG_NPC_OFS:    rd_data = tile_mem_pkg::DATA_W'(npc_q);
        tile_mem_pkg::CFG_DID_OFS:    rd_data = tile_mem_pkg::DATA_W'(did_i);
        default:                      rd_data = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      freeze_q <= 1'b1;
      npc_q    <= RESET_NPC;
      resp_v_q <= 1'b0;
    end
    else
    begin
      if (take && wr && ofs == tile_mem_pkg::CFG_FREEZE_OFS)
        freeze_q <= cmd_i.data[0];
      if (take && wr && ofs == tile_mem_pkg::CFG_NPC_OFS)
        npc_q <= cmd_i.data[tile_mem_pkg::ADDR_W-1:0];
      if (take)
        resp_v_q <= 1'b1;
      else if (resp_ready_i)
        resp_v_q <= 1'b0;
    end
  end

  // Response payload
  always_ff @(posedge clk_i)
  begin
    if (take)
      resp_q <= '{op: cmd_i.op, addr: cmd_i.addr, data: rd_data, tag: cmd_i.tag};
  end

  assign resp_o    = resp_q;
  assign resp_v_o  = resp_v_q;
  assign cfg_bus_o = '{freeze: freeze_q, npc: npc_q, did: did_i};

endmodule

`default_nettype wire

// ==== design/clint_timer.sv ====
/* Core-local interruptor: free-running mtime, mtimecmp and msip bit 0.
   Registers are full 64-bit words; a write to mtime wins over the increment. */
`timescale 1ns/1ps
`default_nettype none

module clint_timer
(
  input  wire                         clk_i,
  input  wire                         rst_i,

  input  wire tile_mem_pkg::mem_msg_s cmd_i,
  input  wire                         cmd_v_i,
  output logic                        cmd_ready_o,

  output tile_mem_pkg::mem_msg_s      resp_o,
  output logic                        resp_v_o,
  input  wire                         resp_ready_i,

  output logic                        timer_irq_o,
  output logic                        software_irq_o
);

  logic [tile_mem_pkg::DATA_W-1:0] mtime_q;
  logic [tile_mem_pkg::DATA_W-1:0] mtimecmp_q;
  logic                            msip_q;
  logic                            resp_v_q;
  tile_mem_pkg::mem_msg_s          resp_q;
  logic                            take;
  logic                            wr;
  logic [tile_mem_pkg::OFS_W-1:0]  ofs;
  logic [tile_mem_pkg::DATA_W-1:0] rd_data;

  assign cmd_ready_o = ~resp_v_q;
  assign take        = cmd_v_i & cmd_ready_o;
  assign wr          = (cmd_i.op == tile_mem_pkg::MEM_WR);
  assign ofs         = cmd_i.addr.lcl.ofs;

  always_comb
  begin
    rd_data = '0;
    if (!wr)
    begin
      case (ofs)
        tile_mem_pkg::CLINT_MSIP_OFS:     rd_data = tile_mem_pkg::DATA_W'(msip_q);
        tile_mem_pkg::CLINT_MTIMECMP_OFS: rd_data = mtimecmp_q;
        tile_mem_pkg::CLINT_MTIME_OFS:    rd_data = mtime_q;
        default:                          rd_data = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
      resp_v_q   <= 1'b0;
    end
    else
    begin
      if (take && wr && ofs == tile_mem_pkg::CLINT_MTIME_OFS)
        mtime_q <= cmd_i.data;
      else
        mtime_q <= mtime_q + 1'b1;

      if (take && wr && ofs == tile_mem_pkg::CLINT_MTIMECMP_OFS)
        mtimecmp_q <= cmd_i.data;
      if (take && wr && ofs == tile_mem_pkg::CLINT_MSIP_OFS)
        msip_q <= cmd_i.data[0];

      if (take)
        resp_v_q <= 1'b1;
      else if (resp_ready_i)
        resp_v_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (take)
      resp_q <= '{op: cmd_i.op, addr: cmd_i.addr, data: rd_data, tag: cmd_i.tag};
  end

  assign resp_o   = resp_q;
  assign resp_v_o = resp_v_q;

  // Levels, not pulses
  assign timer_irq_o    = (mtime_q >= mtimecmp_q);
  assign software_irq_o = msip_q;

endmodule

`default_nettype wire

// ==== design/loopback_dev.sv ====
/* Sink for unmapped local devices. Writes are dropped, reads return zero. */
`timescale 1ns/1ps
`default_nettype none

module loopback_dev
(
  input  wire                         clk_i,
  input  wire                         rst_i,

  input  wire tile_mem_pkg::mem_msg_s cmd_i,
  input  wire                         cmd_v_i,
  output logic                        cmd_ready_o,

  output tile_mem_pkg::mem_msg_s      resp_o,
  output logic                        resp_v_o,
  input  wire                         resp_ready_i
);

  logic                   resp_v_q;
  tile_mem_pkg::mem_msg_s resp_q;
  logic                   take;

  assign cmd_ready_o = ~resp_v_q;
  assign take        = cmd_v_i & cmd_ready_o;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      resp_v_q <= 1'b0;
    else if (take)
      resp_v_q <= 1'b1;
    else if (resp_ready_i)
      resp_v_q <= 1'b0;
  end

  // Echo the header with zero data
  always_ff @(posedge clk_i)
  begin
    if (take)
      resp_q <= '{op: cmd_i.op, addr: cmd_i.addr, data: '0, tag: cmd_i.tag};
  end

  assign resp_o   = resp_q;
  assign resp_v_o = resp_v_q;

endmodule

`default_nettype wire

// ==== design/mem_dispatch.sv ====
/* Combinational command steering by physical address.
   The payload goes to all targets; only the selected one sees valid. */
`timescale 1ns/1ps
`default_nettype none

module mem_dispatch
(
  input  wire tile_mem_pkg::mem_msg_s cmd_i,
  input  wire                         cmd_v_i,
  output logic                        cmd_ready_o,

  output tile_mem_pkg::mem_msg_s      cmd_o,

  output logic                        cfg_v_o,
  input  wire                         cfg_ready_i,
  output logic                        clint_v_o,
  input  wire                         clint_ready_i,
  output logic                        loop_v_o,
  input  wire                         loop_ready_i,
  output logic                        ext_v_o,
  input  wire                         ext_ready_i
);

  logic                               is_local;
  logic [tile_mem_pkg::DEV_W-1:0]     dev;
  logic                               sel_cfg;
  logic                               sel_clint;
  logic                               sel_ext;
  logic                               sel_loop;

  assign is_local = (cmd_i.addr.flat < tile_mem_pkg::DRAM_BASE);
  assign dev      = cmd_i.addr.lcl.dev;

  // One-hot target select
  assign sel_cfg   = is_local & (dev == tile_mem_pkg::CFG_DEV);
  assign sel_clint = is_local & (dev == tile_mem_pkg::CLINT_DEV);
  assign sel_ext   = ~is_local | (dev == tile_mem_pkg::CACHE_DEV);
  assign sel_loop  = ~sel_cfg & ~sel_clint & ~sel_ext;

  assign cmd_o = cmd_i;

  assign cfg_v_o   = cmd_v_i & sel_cfg;
  assign clint_v_o = cmd_v_i & sel_clint;
  assign ext_v_o   = cmd_v_i & sel_ext;
  assign loop_v_o  = cmd_v_i & sel_loop;

  // Ready of the selected target only
  assign cmd_ready_o = (sel_cfg   & cfg_ready_i)
                     | (sel_clint & clint_ready_i)
                     | (sel_ext   & ext_ready_i)
                     | (sel_loop  & loop_ready_i);

endmodule

`default_nettype wire

// ==== design/resp_arbiter.sv ====
/* Fixed-priority response merge, lowest index wins: ext, cfg, clint, loopback.
   No grant lock; a higher-priority arrival takes over a stalled output. */
`timescale 1ns/1ps
`default_nettype none

module resp_arbiter
(
  input  wire tile_mem_pkg::mem_msg_s ext_resp_i,
  input  wire                         ext_v_i,
  output logic                        ext_ready_o,
  input  wire tile_mem_pkg::mem_msg_s cfg_resp_i,
  input  wire                         cfg_v_i,
  output logic                        cfg_ready_o,
  input  wire tile_mem_pkg::mem_msg_s clint_resp_i,
  input  wire                         clint_v_i,
  output logic                        clint_ready_o,
  input  wire tile_mem_pkg::mem_msg_s loop_resp_i,
  input  wire                         loop_v_i,
  output logic                        loop_ready_o,

  output tile_mem_pkg::mem_msg_s      resp_o,
  output logic                        resp_v_o,
  input  wire                         resp_ready_i
);

  localparam int MSG_W = $bits(tile_mem_pkg::mem_msg_s);

  logic [3:0] req;
  logic [3:0] gnt;

  assign req = {loop_v_i, clint_v_i, cfg_v_i, ext_v_i};
  // Isolate lowest set request
  assign gnt = req & (~req + 4'd1);

  assign resp_o = tile_mem_pkg::mem_msg_s'(({MSG_W{gnt[0]}} & ext_resp_i)
                                         | ({MSG_W{gnt[1]}} & cfg_resp_i)
                                         | ({MSG_W{gnt[2]}} & clint_resp_i)
                                         | ({MSG_W{gnt[3]}} & loop_resp_i));
  assign resp_v_o = |req;

  assign ext_ready_o   = gnt[0] & resp_ready_i;
  assign cfg_ready_o   = gnt[1] & resp_ready_i;
  assign clint_ready_o = gnt[2] & resp_ready_i;
  assign loop_ready_o  = gnt[3] & resp_ready_i;

endmodule

`default_nettype wire

// ==== design/tile_mem_pkg.sv ====
/* Shared types and address map of the tile memory complex.
   Messages carry one data word. Addresses below DRAM_BASE are local devices. */
`default_nettype none

package tile_mem_pkg;

  localparam int ADDR_W = 40;
  localparam int DATA_W = 64;
  localparam int TAG_W  = 4;
  localparam int DID_W  = 8;
  localparam int DEV_W  = 4;
  localparam int OFS_W  = 20;

  localparam logic [ADDR_W-1:0] DRAM_BASE = 40'h80_0000_0000;

  // Local device numbers
  localparam logic [DEV_W-1:0] CFG_DEV   = 4'd1;
  localparam logic [DEV_W-1:0] CLINT_DEV = 4'd2;
  localparam logic [DEV_W-1:0] CACHE_DEV = 4'd3;

  // Configuration block offsets
  localparam logic [OFS_W-1:0] CFG_FREEZE_OFS = 20'h00000;
  localparam logic [OFS_W-1:0] CFG_NPC_OFS    = 20'h00008;
  localparam logic [OFS_W-1:0] CFG_DID_OFS    = 20'h00010;

  // Interruptor offsets
  localparam logic [OFS_W-1:0] CLINT_MSIP_OFS     = 20'h00000;
  localparam logic [OFS_W-1:0] CLINT_MTIMECMP_OFS = 20'h04000;
  localparam logic [OFS_W-1:0] CLINT_MTIME_OFS    = 20'h0BFF8;

  typedef enum logic [0:0]
  {
    MEM_RD = 1'b0,
    MEM_WR = 1'b1
  } mem_op_e;

  // Local device view of a physical address
  typedef struct packed
  {
    logic [ADDR_W-DEV_W-OFS_W-1:0] upper;
    logic [DEV_W-1:0]              dev;
    logic [OFS_W-1:0]              ofs;
  } local_addr_s;

  typedef union packed
  {
    logic [ADDR_W-1:0] flat;
    local_addr_s       lcl;
  } mem_addr_u;

  typedef struct packed
  {
    mem_op_e           op;
    mem_addr_u         addr;
    logic [DATA_W-1:0] data;
    logic [TAG_W-1:0]  tag;
  } mem_msg_s;

  typedef struct packed
  {
    logic              freeze;
    logic [ADDR_W-1:0] npc;
    logic [DID_W-1:0]  did;
  } cfg_bus_s;

endpackage

`default_nettype wire

// ==== design/tile_mem_top.sv ====
/* Memory-side device complex: dispatch, cfg, clint, loopback and response merge.
   The external port stands in for the L2 path and must answer every command once. */
`timescale 1ns/1ps
`default_nettype none

module tile_mem_top
#(
  parameter logic [tile_mem_pkg::ADDR_W-1:0] RESET_NPC = 40'h80_0000_0000
)
(
  input  wire                            clk_i,
  input  wire                            rst_i,
  input  wire [tile_mem_pkg::DID_W-1:0]  did_i,

  input  wire tile_mem_pkg::mem_msg_s    cmd_i,
  input  wire                            cmd_v_i,
  output logic                           cmd_ready_o,

  output tile_mem_pkg::mem_msg_s         resp_o,
  output logic                           resp_v_o,
  input  wire                            resp_ready_i,

  output tile_mem_pkg::mem_msg_s         ext_cmd_o,
  output logic                           ext_cmd_v_o,
  input  wire                            ext_cmd_ready_i,

  input  wire tile_mem_pkg::mem_msg_s    ext_resp_i,
  input  wire                            ext_resp_v_i,
  output logic                           ext_resp_ready_o,

  output tile_mem_pkg::cfg_bus_s         cfg_bus_o,
  output logic                           timer_irq_o,
  output logic                           software_irq_o
);

  tile_mem_pkg::mem_msg_s dev_cmd;
  tile_mem_pkg::mem_msg_s cfg_resp;
  tile_mem_pkg::mem_msg_s clint_resp;
  tile_mem_pkg::mem_msg_s loop_resp;
  logic cfg_cmd_v,   cfg_cmd_ready,   cfg_resp_v,   cfg_resp_ready;
  logic clint_cmd_v, clint_cmd_ready, clint_resp_v, clint_resp_ready;
  logic loop_cmd_v,  loop_cmd_ready,  loop_resp_v,  loop_resp_ready;

  // Shared command payload also feeds the external port
  assign ext_cmd_o = dev_cmd;

  mem_dispatch dispatch
  (
    .cmd_i(cmd_i), .cmd_v_i(cmd_v_i), .cmd_ready_o(cmd_ready_o),
    .cmd_o(dev_cmd),
    .cfg_v_o(cfg_cmd_v), .cfg_ready_i(cfg_cmd_ready),
    .clint_v_o(clint_cmd_v), .clint_ready_i(clint_cmd_ready),
    .loop_v_o(loop_cmd_v), .loop_ready_i(loop_cmd_ready),
    .ext_v_o(ext_cmd_v_o), .ext_ready_i(ext_cmd_ready_i)
  );

  cfg_regs #(.RESET_NPC(RESET_NPC)) cfg
  (
    .clk_i(clk_i), .rst_i(rst_i),
    .cmd_i(dev_cmd), .cmd_v_i(cfg_cmd_v), .cmd_ready_o(cfg_cmd_ready),
    .resp_o(cfg_resp), .resp_v_o(cfg_resp_v), .resp_ready_i(cfg_resp_ready),
    .did_i(did_i), .cfg_bus_o(cfg_bus_o)
  );

  clint_timer clint
  (
    .clk_i(clk_i), .rst_i(rst_i),
    .cmd_i(dev_cmd), .cmd_v_i(clint_cmd_v), .cmd_ready_o(clint_cmd_ready),
    .resp_o(clint_resp), .resp_v_o(clint_resp_v), .resp_ready_i(clint_resp_ready),
    .timer_irq_o(timer_irq_o), .software_irq_o(software_irq_o)
  );

  loopback_dev loopback
  (
    .clk_i(clk_i), .rst_i(rst_i),
    .cmd_i(dev_cmd), .cmd_v_i(loop_cmd_v), .cmd_ready_o(loop_cmd_ready),
    .resp_o(loop_resp), .resp_v_o(loop_resp_v), .resp_ready_i(loop_resp_ready)
  );

  resp_arbiter arbiter
  (
    .ext_resp_i(ext_resp_i), .ext_v_i(ext_resp_v_i), .ext_ready_o(ext_resp_ready_o),
    .cfg_resp_i(cfg_resp), .cfg_v_i(cfg_resp_v), .cfg_ready_o(cfg_resp_ready),
    .clint_resp_i(clint_resp), .clint_v_i(clint_resp_v), .clint_ready_o(clint_resp_ready),
    .loop_resp_i(loop_resp), .loop_v_i(loop_resp_v), .loop_ready_o(loop_resp_ready),
    .resp_o(resp_o), .resp_v_o(resp_v_o), .resp_ready_i(resp_ready_i)
  );

endmodule

`default_nettype wire

// ==== list.f ====
design/tile_mem_pkg.sv
design/mem_dispatch.sv
design/resp_arbiter.sv
design/cfg_regs.sv
design/clint_timer.sv
design/loopback_dev.sv
design/tile_mem_top.sv
bench/tile_mem_checker.sv
bench/tile_mem_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the tile memory testbench with Verilator.
# The exit status is the simulator's; a failing run ends in $fatal.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tile_mem_tb \
  -f list.f \
  -o tile_mem_sim

./obj_dir/tile_mem_sim
